// File: source/ntm_math_pkg.sv
// NTM math library shared definitions
// Element and result widths for the vector logarithm unit,
// fixed-point format constants, plain vector types and the
// state encodings of the scalar engine and the vector controller

package ntm_math_pkg;

  ////////////////////////////////////////
  // Widths
  ////////////////////////////////////////

  // One element in, one result out
  localparam int DATA_SIZE    = 32;
  // Q16.16 on both sides
  localparam int FRAC_BITS    = 16;
  // Vector length and element index
  localparam int CONTROL_SIZE = 8;
  // Normalized mantissa, unsigned Q1.31
  localparam int MANT_SIZE    = 32;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  // Unsigned element or signed Q16.16 result
  typedef logic [DATA_SIZE-1:0]    data_t;
  typedef logic [CONTROL_SIZE-1:0] control_t;
  // Bit index 0 to 31
  typedef logic [4:0]              position_t;
  typedef logic [MANT_SIZE-1:0]    mantissa_t;

  // Scalar engine sequence
  typedef enum logic [1:0] {
    IDLE,
    NORMALIZE,
    ITERATE,
    DONE
  } scalar_state_t;

  // Vector controller sequence
  typedef enum logic [1:0] {
    STARTER,
    INPUT,
    ENDER
  } vector_state_t;

  ////////////////////////////////////////
  // Constants
  ////////////////////////////////////////

  // log2(0) marker, most negative value
  localparam data_t LOG_ZERO_RESULT = {1'b1, {(DATA_SIZE-1){1'b0}}};

endpackage

// File: source/ntm_leading_one_detector.sv
// Leading-one detector
// Purely combinational priority encoder over one operand word.
// Gives the index of the highest set bit and flags an all-zero word.
// Feeds the integer part and the normalize shift of the log engine

`timescale 1ns/1ps

module ntm_leading_one_detector
  import ntm_math_pkg::*;
(
  // Operand
  input  data_t     data_in,

  // Highest set bit
  output position_t leading_position,

  // No bit set at all
  output logic      is_zero
);

  ////////////////////////////////////////
  // Priority encoder
  ////////////////////////////////////////

  // Scan from bit 0 upward
  // Later hits overwrite earlier ones so the top set bit wins
  always_comb begin
    leading_position = '0;
    for (int i = 0; i < DATA_SIZE; i++) begin
      if (data_in[i]) begin
        leading_position = position_t'(i);
      end
    end
  end

  ////////////////////////////////////////
  // Zero flag
  ////////////////////////////////////////

  // Position reads 0 for both 1 and 0
  // This flag tells them apart
  assign is_zero = (data_in == '0);

endmodule

// File: source/ntm_scalar_logarithm_function.sv
// Scalar base-2 logarithm engine
// Unsigned Q16.16 operand in, signed Q16.16 result out.
// Integer part from the leading-one position, then 16 fraction
// bits by repeated squaring of the normalized mantissa, one bit
// per cycle. Fixed latency of 18 cycles for every operand

`timescale 1ns/1ps

module ntm_scalar_logarithm_function
  import ntm_math_pkg::*;
(
  // Global
  input  logic  CLK,
  input  logic  RST,

  // Control
  input  logic  START,
  output logic  READY,

  // Data
  input  data_t DATA_IN,
  output data_t DATA_OUT
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // FSM
  scalar_state_t state;

  // Remaining iterations after the current one
  logic [$clog2(FRAC_BITS)-1:0] iter_count;

  // Captured operand, also the detector input
  data_t operand;

  // Detector outputs
  position_t leading_position;
  logic      is_zero;

  // Operand was zero
  logic zero_flag;

  // Q1.31 mantissa, value in [1, 2)
  mantissa_t mantissa;

  // Square of the mantissa in Q2.62
  logic [2*MANT_SIZE-1:0] mant_wide;
  logic [2*MANT_SIZE-1:0] square;
  logic                   square_ge_two;

  // Signed integer part, range -16 to 15
  logic [DATA_SIZE-FRAC_BITS-1:0] int_part;

  // Fraction bits, MSB produced first
  logic [FRAC_BITS-1:0] frac_bits;

  // Assembled result
  data_t result;

  ////////////////////////////////////////
  // Leading one
  ////////////////////////////////////////

  ntm_leading_one_detector leading_one_detector (
    .data_in         (operand),
    .leading_position(leading_position),
    .is_zero         (is_zero)
  );

  ////////////////////////////////////////
  // Square and compare
  ////////////////////////////////////////

  // Widen before multiply so no product bits are lost
  assign mant_wide = {{MANT_SIZE{1'b0}}, mantissa};
  assign square    = mant_wide * mant_wide;

  // Top bit of Q2.62 set means square >= 2
  assign square_ge_two = square[2*MANT_SIZE-1];

  // Integer part joined with fraction
  assign result = zero_flag ? LOG_ZERO_RESULT : {int_part, frac_bits};

  ////////////////////////////////////////
  // Control
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state      <= IDLE;
      iter_count <= '0;
      READY      <= 1'b0;
      DATA_OUT   <= '0;
    end else begin
      // Single-cycle pulse
      READY <= 1'b0;

      case (state)
        IDLE: begin
          if (START) begin
            state <= NORMALIZE;
          end
        end
        NORMALIZE: begin
          // 16 iterations follow
          iter_count <= ($clog2(FRAC_BITS))'(FRAC_BITS - 1);
          state      <= ITERATE;
        end
        ITERATE: begin
          if (iter_count == '0) begin
            state <= DONE;
          end else begin
            iter_count <= iter_count - 1'b1;
          end
        end
        DONE: begin
          // Held until the next operand finishes
          DATA_OUT <= result;
          READY    <= 1'b1;
          state    <= IDLE;
        end
        default: begin
          state <= IDLE;
        end
      endcase
    end
  end

  ////////////////////////////////////////
  // Datapath
  ////////////////////////////////////////

  always_ff @(posedge CLK) begin
    case (state)
      IDLE: begin
        if (START) begin
          operand <= DATA_IN;
        end
      end
      NORMALIZE: begin
        zero_flag <= is_zero;

        // Input has 16 fraction bits, so bit 16 means 2^0
        int_part <= (DATA_SIZE-FRAC_BITS)'(leading_position)
                  - (DATA_SIZE-FRAC_BITS)'(FRAC_BITS);

        // Move the leading one to bit 31
        // Zero operand just gives a zero mantissa
        mantissa <= mantissa_t'(operand << (position_t'(DATA_SIZE - 1) - leading_position));
      end
      ITERATE: begin
        frac_bits <= {frac_bits[FRAC_BITS-2:0], square_ge_two};

        // Halve when >= 2 to stay in [1, 2)
        if (square_ge_two) begin
          mantissa <= square[2*MANT_SIZE-1 -: MANT_SIZE];
        end else begin
          mantissa <= square[2*MANT_SIZE-2 -: MANT_SIZE];
        end
      end
      default: begin
      end
    endcase
  end

endmodule

// File: source/ntm_vector_logarithm_function.sv
// Vector logarithm unit, top level
// Element-wise base-2 logarithm over a vector of unsigned Q16.16
// numbers. Vector length is taken at START, elements arrive one
// at a time and go through the scalar engine. Each result leaves
// with a DATA_OUT_ENABLE pulse, READY marks the end of the vector

`timescale 1ns/1ps

module ntm_vector_logarithm_function
  import ntm_math_pkg::*;
(
  // Global
  input  logic     CLK,
  input  logic     RST,

  // Control
  input  logic     START,
  output logic     READY,

  input  logic     DATA_IN_ENABLE,
  output logic     DATA_OUT_ENABLE,

  // Data
  input  control_t SIZE_IN,
  input  data_t    DATA_IN,
  output data_t    DATA_OUT
);

  ////////////////////////////////////////
  // Signals
  ////////////////////////////////////////

  // FSM
  vector_state_t state;

  // Length captured at START
  control_t size_reg;

  // Elements already returned
  control_t index_loop;
  control_t index_next;

  // Element taken this cycle
  logic accept_element;

  // Scalar engine handshake
  logic  start_scalar;
  logic  ready_scalar;
  data_t data_in_scalar;
  data_t data_out_scalar;

  ////////////////////////////////////////
  // Element acceptance
  ////////////////////////////////////////

  // Strobe only counts in INPUT with elements still owed
  assign accept_element = (state == INPUT) && (size_reg != '0) && DATA_IN_ENABLE;

  assign index_next = index_loop + control_t'(1);

  ////////////////////////////////////////
  // Control FSM
  ////////////////////////////////////////

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state           <= STARTER;
      size_reg        <= '0;
      index_loop      <= '0;
      start_scalar    <= 1'b0;
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      DATA_OUT        <= '0;
    end else begin
      // All pulses default low
      READY           <= 1'b0;
      DATA_OUT_ENABLE <= 1'b0;
      start_scalar    <= 1'b0;

      case (state)
        STARTER: begin
          if (START) begin
            size_reg   <= SIZE_IN;
            index_loop <= '0;
            state      <= INPUT;
          end
        end
        INPUT: begin
          if (size_reg == '0) begin
            // Empty vector, finish right away
            READY <= 1'b1;
            state <= STARTER;
          end else if (accept_element) begin
            start_scalar <= 1'b1;
            state        <= ENDER;
          end
        end
        ENDER: begin
          if (ready_scalar) begin
            DATA_OUT        <= data_out_scalar;
            DATA_OUT_ENABLE <= 1'b1;

            if (index_next == size_reg) begin
              // Last element, READY with its output
              READY <= 1'b1;
              state <= STARTER;
            end else begin
              index_loop <= index_next;
              state      <= INPUT;
            end
          end
        end
        default: begin
          state <= STARTER;
        end
      endcase
    end
  end

  // Operand for the engine
  always_ff @(posedge CLK) begin
    if (accept_element) begin
      data_in_scalar <= DATA_IN;
    end
  end

  ////////////////////////////////////////
  // Scalar engine
  ////////////////////////////////////////

  ntm_scalar_logarithm_function scalar_logarithm_function (
    .CLK     (CLK),
    .RST     (RST),
    .START   (start_scalar),
    .READY   (ready_scalar),
    .DATA_IN (data_in_scalar),
    .DATA_OUT(data_out_scalar)
  );

endmodule

// File: verification/ntm_vector_logarithm_properties.sv
// Control pulse assertions for the vector logarithm unit
// Bound into the top level next to its control FSM

`timescale 1ns/1ps

module ntm_vector_logarithm_properties
  import ntm_math_pkg::*;
(
  input logic     CLK,
  input logic     RST,
  input logic     READY,
  input logic     DATA_OUT_ENABLE,
  input control_t size_reg
);

  // Assertion failures so far
  int failure_count = 0;

  ready_pulse: assert property (@(posedge CLK) disable iff (RST) READY |=> !READY)
    else begin
      failure_count++;
      $error("READY held high for more than one cycle");
    end

  output_pulse: assert property (@(posedge CLK) disable iff (RST)
    DATA_OUT_ENABLE |=> !DATA_OUT_ENABLE)
    else begin
      failure_count++;
      $error("DATA_OUT_ENABLE held high for more than one cycle");
    end

  // Lone READY only closes an empty vector
  empty_ready: assert property (@(posedge CLK) disable iff (RST)
    (READY && !DATA_OUT_ENABLE) |-> (size_reg == '0))
    else begin
      failure_count++;
      $error("READY without an output on a vector that is not empty");
    end

endmodule

bind ntm_vector_logarithm_function ntm_vector_logarithm_properties pulse_properties (
  .CLK            (CLK),
  .RST            (RST),
  .READY          (READY),
  .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
  .size_reg       (size_reg)
);

// File: verification/ntm_vector_logarithm_checker.sv
// Vector logarithm monitor
// Follows the host side of the unit, recomputes each log2 result in
// integer arithmetic and checks value, latency, length and READY

`timescale 1ns/1ps

module ntm_vector_logarithm_checker
  import ntm_math_pkg::*;
(
  input  logic     CLK,
  input  logic     RST,
  input  logic     START,
  input  control_t SIZE_IN,
  input  logic     DATA_IN_ENABLE,
  input  data_t    DATA_IN,
  input  logic     READY,
  input  logic     DATA_OUT_ENABLE,
  input  data_t    DATA_OUT,
  // Test boundary
  input  logic     test_done,
  input  int       test_number,
  output int       check_count,
  output int       error_count
);

  // Edge that registers an output, counted from the accepting edge
  localparam int ELEMENT_LATENCY = 20;
  // READY after START for an empty vector
  localparam int EMPTY_LATENCY   = 2;
  // 2.0 in Q2.62
  localparam longint unsigned TWO_Q62 = 64'h8000_0000_0000_0000;

  int    checks = 0;
  int    errors = 0;
  int    test_checks = 0;
  int    test_errors = 0;
  int    cycle = 0;
  int    reset_samples = 0;
  bit    active = 1'b0;
  bit    in_flight = 1'b0;
  int    size_expected;
  int    out_count;
  int    start_cycle;
  int    accept_cycle;
  data_t element;

  assign check_count = checks;
  assign error_count = errors;

  // Reference log2, Q16.16 in and out
  function automatic data_t log2_model(input data_t value);
    position_t         top;
    logic [31:0]       mant;
    longint unsigned   sq;
    logic [15:0]       frac;
    if (value == '0) begin
      return {1'b1, 31'b0};
    end
    top = 5'd31;
    while (!value[top]) begin
      top = top - 5'd1;
    end
    mant = value << (5'd31 - top);
    frac = '0;
    for (int i = 0; i < FRAC_BITS; i++) begin
      sq = 64'(mant) * 64'(mant);
      frac = {frac[14:0], sq >= TWO_Q62};
      mant = (sq >= TWO_Q62) ? 32'(sq >> 32) : 32'(sq >> 31);
    end
    return {16'(int'(top) - FRAC_BITS), frac};
  endfunction

  task automatic mismatch(input string message);
    errors++;
    test_errors++;
    $display("MISMATCH at %0t: %s", $time, message);
  endtask

  task automatic protocol_error(input string message);
    errors++;
    test_errors++;
    $display("Protocol error at %0t: %s", $time, message);
  endtask

  task automatic expect_value(input string what, input data_t got, input data_t want);
    checks++;
    test_checks++;
    if (got !== want) begin
      mismatch($sformatf("%s: expected %h got %h", what, want, got));
    end
  endtask

  always @(posedge CLK) begin
    cycle++;
    if (RST) begin
      active = 1'b0;
      in_flight = 1'b0;
      reset_samples++;
      // First sample may come before reset has acted
      if (reset_samples > 1) begin
        expect_value("READY in reset", data_t'(READY), '0);
        expect_value("DATA_OUT_ENABLE in reset", data_t'(DATA_OUT_ENABLE), '0);
        expect_value("DATA_OUT in reset", DATA_OUT, '0);
      end
    end else begin
      if (DATA_OUT_ENABLE) begin
        if (!in_flight) begin
          protocol_error("DATA_OUT_ENABLE with no element in flight");
        end else begin
          in_flight = 1'b0;
          out_count++;
          expect_value($sformatf("log2 of %h", element), DATA_OUT, log2_model(element));
          if (element != '0 && (element & (element - 1)) == '0) begin
            expect_value($sformatf("power of two %h", element), DATA_OUT,
                         {16'($clog2(element) - FRAC_BITS), 16'h0000});
          end
          checks += 2;
          test_checks += 2;
          // Output seen one edge after it was registered
          if (cycle - 1 - accept_cycle != ELEMENT_LATENCY) begin
            mismatch($sformatf("output latency %0d cycles, expected %0d",
                               cycle - 1 - accept_cycle, ELEMENT_LATENCY));
          end
          if (out_count == size_expected) begin
            active = 1'b0;
            if (!READY) begin
              protocol_error("READY missing on the last output of the vector");
            end
          end else if (READY) begin
            protocol_error("READY before the last output of the vector");
          end
        end
      end else if (READY) begin
        checks++;
        test_checks++;
        if (active && size_expected == 0) begin
          active = 1'b0;
          if (cycle - start_cycle != EMPTY_LATENCY) begin
            mismatch($sformatf("empty vector READY after %0d cycles, expected %0d",
                               cycle - start_cycle, EMPTY_LATENCY));
          end
        end else begin
          protocol_error("READY without an output outside an empty vector");
        end
      end

      // START only counts between vectors
      if (!active && START) begin
        active = 1'b1;
        size_expected = int'(SIZE_IN);
        out_count = 0;
        start_cycle = cycle;
      end else if (active && !in_flight && size_expected != 0 && DATA_IN_ENABLE) begin
        in_flight = 1'b1;
        element = DATA_IN;
        accept_cycle = cycle;
      end
    end

    if (test_done) begin
      $display("Test %0d finished: %0d checks, %0d errors", test_number, test_checks,
               test_errors);
      test_checks = 0;
      test_errors = 0;
    end
  end

endmodule

// File: verification/ntm_vector_logarithm_tb.sv
// Vector logarithm unit testbench
// Random vectors from a fixed seed, sent element by element with
// stray strobes while the unit is busy. The monitor does the checks

`timescale 1ns/1ps

module ntm_vector_logarithm_tb
  import ntm_math_pkg::*;
();

  localparam int unsigned SEED       = 32'h4ea53614;
  localparam int NUM_TESTS           = 5;
  localparam int VECTORS_PER_TEST    = 4;
  localparam int NUM_VECTORS         = NUM_TESTS * VECTORS_PER_TEST;
  localparam int RESET_CYCLES        = 10;
  localparam int CYCLES_PER_ELEMENT  = 25;
  // Stray strobes stop well before the result returns
  localparam int BUSY_WINDOW         = 10;

  logic     CLK = 1'b0;
  logic     RST;
  logic     START;
  control_t SIZE_IN;
  logic     DATA_IN_ENABLE;
  data_t    DATA_IN;
  logic     READY;
  logic     DATA_OUT_ENABLE;
  data_t    DATA_OUT;
  logic     test_done;
  int       test_number;
  int       check_count;
  int       error_count;
  int       watchdog_cycles = 0;
  int       vector_lengths [NUM_VECTORS];

  always #10 CLK = ~CLK;

  ntm_vector_logarithm_function uut (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .READY          (READY),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN        (DATA_IN),
    .DATA_OUT       (DATA_OUT)
  );

  ntm_vector_logarithm_checker monitor (
    .CLK            (CLK),
    .RST            (RST),
    .START          (START),
    .SIZE_IN        (SIZE_IN),
    .DATA_IN_ENABLE (DATA_IN_ENABLE),
    .DATA_IN        (DATA_IN),
    .READY          (READY),
    .DATA_OUT_ENABLE(DATA_OUT_ENABLE),
    .DATA_OUT       (DATA_OUT),
    .test_done      (test_done),
    .test_number    (test_number),
    .check_count    (check_count),
    .error_count    (error_count)
  );

  ////////////////////////////////////////
  // Stimulus helpers
  ////////////////////////////////////////

  // Zero, power of two or anything
  function automatic data_t random_element();
    int kind;
    kind = int'($urandom % 4);
    case (kind)
      0:       return '0;
      1:       return data_t'(1) << ($urandom % 32);
      default: return data_t'($urandom);
    endcase
  endfunction

  // One element, then wait for its result
  task automatic send_element();
    data_t value;
    int    waited;
    value = random_element();
    DATA_IN_ENABLE <= 1'b1;
    DATA_IN        <= value;
    @(posedge CLK);
    waited = 0;
    do begin
      DATA_IN_ENABLE <= (waited < BUSY_WINDOW) && ($urandom % 4 == 0);
      START          <= (waited < BUSY_WINDOW) && ($urandom % 8 == 0);
      DATA_IN        <= data_t'($urandom);
      SIZE_IN        <= control_t'($urandom);
      @(posedge CLK);
      waited++;
    end while (!DATA_OUT_ENABLE);
  endtask

  task automatic run_vector(input int length);
    START   <= 1'b1;
    SIZE_IN <= control_t'(length);
    @(posedge CLK);
    START   <= 1'b0;
    // Length is held inside from here on
    SIZE_IN <= control_t'($urandom);
    if (length == 0) begin
      do begin
        @(posedge CLK);
      end while (!READY);
    end else begin
      for (int i = 0; i < length; i++) begin
        send_element();
      end
    end
  endtask

  task automatic finish_test(input int number);
    test_number <= number;
    test_done   <= 1'b1;
    @(posedge CLK);
    test_done   <= 1'b0;
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    int total_elements;
    void'($urandom(SEED));
    RST            <= 1'b1;
    START          <= 1'b0;
    SIZE_IN        <= '0;
    DATA_IN_ENABLE <= 1'b0;
    DATA_IN        <= '0;
    test_done      <= 1'b0;
    test_number    <= 0;

    // Very first vector is empty
    total_elements = 0;
    for (int v = 0; v < NUM_VECTORS; v++) begin
      vector_lengths[v] = (v == 0) ? 0 : int'($urandom % 13);
      total_elements += vector_lengths[v];
    end
    watchdog_cycles = total_elements * CYCLES_PER_ELEMENT + NUM_VECTORS * 4
                    + NUM_TESTS + RESET_CYCLES + 100;

    repeat (RESET_CYCLES) @(posedge CLK);
    RST <= 1'b0;
    @(posedge CLK);

    for (int t = 0; t < NUM_TESTS; t++) begin
      for (int v = 0; v < VECTORS_PER_TEST; v++) begin
        run_vector(vector_lengths[t * VECTORS_PER_TEST + v]);
      end
      finish_test(t);
    end
    @(posedge CLK);

    $display("Summary: %0d checks, %0d errors, %0d assertion failures", check_count,
             error_count, uut.pulse_properties.failure_count);
    if (error_count == 0 && uut.pulse_properties.failure_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    wait (watchdog_cycles > 0);
    repeat (watchdog_cycles) @(posedge CLK);
    $display("Watchdog expired after %0d cycles, the DUT stopped responding",
             watchdog_cycles);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: project.f
source/ntm_math_pkg.sv
source/ntm_leading_one_detector.sv
source/ntm_scalar_logarithm_function.sv
source/ntm_vector_logarithm_function.sv
verification/ntm_vector_logarithm_properties.sv
verification/ntm_vector_logarithm_checker.sv
verification/ntm_vector_logarithm_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Build and run the vector logarithm testbench with Verilator

set -e
set -o pipefail

cd "$(dirname "$0")"

TOP=ntm_vector_logarithm_tb
LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --assert --top-module "$TOP" -f project.f

./obj_dir/V"$TOP" | tee "$LOG"

if grep -q "CHECKS FAILED" "$LOG"; then
  echo "Simulation reported failures, see $LOG"
  exit 1
fi

echo "Simulation finished cleanly"
